//--- compile.f
+incdir+verilog
verilog/mpuPkg.sv
verilog/mpuSessionCtrl.sv
verilog/i2cCmdSequencer.sv
verilog/mpuSampleAssembler.sv
verilog/mpuController.sv
test/tbClockGen.sv
test/tbI2cEngineModel.sv
test/tbMpuController.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/10ps -j 0
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/10ps
TOP       := tbMpuController
FILELIST  := compile.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- test/tbMpuController.sv
`timescale 1ns/10ps
`include "mpu_config.svh"

module tbMpuController;

    localparam int unsigned INIT_CMDS      = 15;                    // Five write triples
    localparam int unsigned BURST_CMDS     = 3 + `MPU_BURST_LEN;    // Header plus receives
    localparam int unsigned TIMEOUT_CYCLES = 2000;

    logic                          clk;
    logic                          rst;
    logic                          enSample;
    logic                          errInject;
    logic                          busyOut;
    logic                          errorI2c;
    logic                          sampleValid;
    mpuPkg::mpuWord_t              acX;
    mpuPkg::mpuWord_t              acY;
    mpuPkg::mpuWord_t              acZ;
    mpuPkg::mpuWord_t              gyX;
    mpuPkg::mpuWord_t              gyY;
    mpuPkg::mpuWord_t              gyZ;
    logic                          enI2c;
    logic                          startBit;
    logic                          stopBit;
    logic                          ackNack;
    logic                          rwBit;
    mpuPkg::mpuByte_t              outByte;
    logic                          engBusy;
    logic                          engErr;
    mpuPkg::mpuByte_t              inByte;
    logic                          cmdTaken;
    logic [11:0]                   cmdWord;     // start, stop, ackNack, rw, byte
    logic [31:0]                   cmdCount;
    logic [8*`MPU_BURST_LEN-1:0]   burstBytes;
    int unsigned                   cycleCount = 0;

    tbClockGen uClock (
        .clk_o (clk)
    );

    mpuController DUT (
        .clk           (clk),
        .rst           (rst),
        .en_i          (enSample),
        .busy_o        (busyOut),
        .errorI2c_o    (errorI2c),
        .acX_o         (acX),
        .acY_o         (acY),
        .acZ_o         (acZ),
        .gyX_o         (gyX),
        .gyY_o         (gyY),
        .gyZ_o         (gyZ),
        .sampleValid_o (sampleValid),
        .enI2c_o       (enI2c),
        .start_o       (startBit),
        .stop_o        (stopBit),
        .ackNack_o     (ackNack),
        .rw_o          (rwBit),
        .outByte_o     (outByte),
        .busy_i        (engBusy),
        .err_i         (engErr),
        .inByte_i      (inByte)
    );

    tbI2cEngineModel uEngine (
        .clk          (clk),
        .rst          (rst),
        .enI2c_i      (enI2c),
        .start_i      (startBit),
        .stop_i       (stopBit),
        .ackNack_i    (ackNack),
        .rw_i         (rwBit),
        .outByte_i    (outByte),
        .errInject_i  (errInject),
        .busy_o       (engBusy),
        .err_o        (engErr),
        .inByte_o     (inByte),
        .cmdTaken_o   (cmdTaken),
        .cmdWord_o    (cmdWord),
        .cmdCount_o   (cmdCount),
        .burstBytes_o (burstBytes)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of the byte command stream
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [15:0] initWrite(input int unsigned k);
        case (k)
            0:       return {`MPU_REG_CONF, `MPU_VAL_FSYNC_OFF};
            1:       return {`MPU_REG_CONF, `MPU_VAL_LPF_184};
            2:       return {`MPU_REG_GYRO, `MPU_VAL_GYRO_250};
            3:       return {`MPU_REG_ACC, `MPU_VAL_ACC_2G};
            default: return {`MPU_REG_PWR, `MPU_VAL_WAKE};
        endcase
    endfunction

    function automatic logic [11:0] expectedCmd(input int unsigned idx);
        int unsigned pos;
        logic [15:0] regVal;
        if (idx < INIT_CMDS) begin
            pos    = idx % 3;
            regVal = initWrite(idx / 3);
            if (pos == 0) return {4'b1001, `MPU_ADDR_W};
            if (pos == 1) return {4'b0001, regVal[15:8]};
            return {4'b0101, regVal[7:0]};          // Data closes with stop
        end
        pos = (idx - INIT_CMDS) % BURST_CMDS;
        if (pos == 0) return {4'b1001, `MPU_ADDR_W};
        if (pos == 1) return {4'b0001, `MPU_REG_DATA};
        if (pos == 2) return {4'b1001, `MPU_ADDR_R};   // Repeated start
        if (pos - 3 == `MPU_BURST_LEN - 1) return {4'b0110, 8'h00};
        return {4'b0000, 8'h00};                    // ACKed receive
    endfunction

    function automatic logic endsSession(input int unsigned n);
        return n == INIT_CMDS || (n > INIT_CMDS && (n - INIT_CMDS) % BURST_CMDS == 0);
    endfunction

    // Big-endian pair for reading n, acc X/Y/Z then gyro X/Y/Z
    function automatic logic [15:0] burstWord(input logic [8*`MPU_BURST_LEN-1:0] bytes,
                                              input int unsigned n);
        int unsigned hi;
        hi = 2 * n;
        if (hi >= `MPU_TEMP_FIRST) hi = hi + 2;    // Skip the temperature pair
        return {bytes[8*hi +: 8], bytes[8*(hi+1) +: 8]};
    endfunction

    task automatic stopOnError(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "Check failed");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    resetState: assert property (
        @(posedge clk)
        $fell(rst) |-> busyOut && !errorI2c && !enI2c && !sampleValid &&
                       {acX, acY, acZ, gyX, gyY, gyZ} == '0
    ) else stopOnError("outputs are not in their reset state after reset");

    cmdMatches: assert property (
        @(posedge clk) disable iff (rst)
        cmdTaken |-> busyOut && cmdWord == expectedCmd(cmdCount - 32'd1)
    ) else stopOnError($sformatf("command %0d is %h, expected %h", cmdCount - 32'd1,
                                 cmdWord, expectedCmd(cmdCount - 32'd1)));

    idleQuiet: assert property (
        @(posedge clk) disable iff (rst)
        !busyOut |-> !enI2c
    ) else stopOnError("engine enabled while the controller is not busy");

    idleFollowsEn: assert property (
        @(posedge clk) disable iff (rst)
        !busyOut && !errorI2c |=> busyOut == $past(enSample)
    ) else stopOnError("busy does not follow en in idle");

    busyEndsAtBoundary: assert property (
        @(posedge clk) disable iff (rst)
        $fell(busyOut) && !errorI2c |-> endsSession(cmdCount)
    ) else stopOnError($sformatf("busy fell after %0d commands", cmdCount));

    sampleTiming: assert property (
        @(posedge clk) disable iff (rst)
        $fell(engBusy) && !cmdWord[8] && cmdWord[10] |=>
            sampleValid && !busyOut ##1 !sampleValid
    ) else stopOnError("sample pulse or busy drop not one cycle after the last byte");

    sampleData: assert property (
        @(posedge clk) disable iff (rst)
        sampleValid |-> acX == burstWord(burstBytes, 0) && acY == burstWord(burstBytes, 1) &&
                        acZ == burstWord(burstBytes, 2) && gyX == burstWord(burstBytes, 3) &&
                        gyY == burstWord(burstBytes, 4) && gyZ == burstWord(burstBytes, 5)
    ) else stopOnError("published readings differ from the bytes sent by the engine");

    errorRises: assert property (
        @(posedge clk) disable iff (rst)
        engErr |=> errorI2c
    ) else stopOnError("errorI2c_o did not rise the cycle after err_i");

    errorHalts: assert property (
        @(posedge clk) disable iff (rst)
        errorI2c |-> !busyOut && !enI2c
    ) else stopOnError("controller still active in the error state");

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic applyReset();
        @(negedge clk);
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic waitSessionIdle();
        @(negedge clk);
        while (busyOut) @(negedge clk);
    endtask

    task automatic requestSample();
        @(negedge clk);
        enSample = 1'b1;
        @(negedge clk);
        enSample = 1'b0;
    endtask

    task automatic waitForSample();
        while (!sampleValid) @(negedge clk);
    endtask

    // Engine outputs move on the falling edge, so watch them on the rising one
    task automatic waitForCommands(input int unsigned n);
        @(posedge clk);
        while (cmdCount < n) @(posedge clk);
    endtask

    initial begin
        rst       = 1'b1;
        enSample  = 1'b0;
        errInject = 1'b0;
        applyReset();
        waitSessionIdle();                  // Five init writes done
        repeat (20) @(negedge clk);
        repeat (3) begin
            requestSample();
            waitForSample();
            repeat (5) @(negedge clk);
        end
        requestSample();
        waitForCommands(INIT_CMDS + 3 * BURST_CMDS + 8);   // A few receives in
        errInject = 1'b1;
        @(negedge clk);
        while (!errorI2c) @(negedge clk);
        @(posedge clk);
        errInject = 1'b0;
        repeat (50) @(negedge clk);         // Must stay silent
        applyReset();
        waitSessionIdle();                  // Init runs again
        repeat (5) @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles before the tests finished", cycleCount);
            $display("FAIL: see errors above");
            $fatal(1, "Timeout");
        end
    end

endmodule

//--- test/tbI2cEngineModel.sv
`timescale 1ns/10ps
`include "mpu_config.svh"

module tbI2cEngineModel (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          enI2c_i,
    input  logic                          start_i,
    input  logic                          stop_i,
    input  logic                          ackNack_i,
    input  logic                          rw_i,
    input  logic [7:0]                    outByte_i,
    input  logic                          errInject_i,
    output logic                          busy_o,
    output logic                          err_o,
    output logic [7:0]                    inByte_o,
    output logic                          cmdTaken_o,
    output logic [11:0]                   cmdWord_o,
    output logic [31:0]                   cmdCount_o,
    output logic [8*`MPU_BURST_LEN-1:0]   burstBytes_o
);

    integer                        seed = 16339;
    logic                          rstSeen = 1'b1;
    logic                          busy = 1'b0;
    logic                          err = 1'b0;
    logic [7:0]                    rxData = 8'h00;
    logic                          curRw;
    logic                          curStop;
    int unsigned                   remaining;
    logic [7:0]                    rxByte;
    logic [7:0]                    rxQueue [$];    // Read bytes handed out, oldest first
    logic [8*`MPU_BURST_LEN-1:0]   burst;
    int                            i;

    assign busy_o   = busy;
    assign err_o    = err;
    assign inByte_o = rxData;

    // Reset changes on the falling edge, so take it on the rising one
    always @(posedge clk) begin
        rstSeen <= rst;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte engine, one command at a time
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        cmdTaken_o <= 1'b0;
        err        <= 1'b0;
        if (rstSeen) begin
            busy         <= 1'b0;
            rxData       <= 8'h00;
            cmdWord_o    <= '0;
            cmdCount_o   <= '0;
            burstBytes_o <= '0;
            rxQueue.delete();
        end else if (busy) begin
            if (errInject_i && !curRw) begin
                busy <= 1'b0;       // Receive aborted with an error
                err  <= 1'b1;
            end else if (remaining != 0) begin
                remaining = remaining - 1;
            end else begin
                busy <= 1'b0;
                if (!curRw) begin
                    rxByte = 8'($random(seed));
                    rxData <= rxByte;   // Valid as busy drops
                    rxQueue.push_back(rxByte);
                    if (curStop && rxQueue.size() >= `MPU_BURST_LEN) begin
                        for (i = 0; i < `MPU_BURST_LEN; i++) begin
                            burst[8*i +: 8] = rxQueue.pop_front();
                        end
                        burstBytes_o <= burst;  // Byte 0 in the low bits
                    end
                end
            end
        end else if (enI2c_i) begin
            busy       <= 1'b1;
            curRw      = rw_i;
            curStop    = stop_i;
            remaining  = 1 + ($unsigned($random(seed)) % 8);   // Busy for 2 to 9 cycles
            cmdTaken_o <= 1'b1;
            cmdWord_o  <= {start_i, stop_i, ackNack_i, rw_i, rw_i ? outByte_i : 8'h00};
            cmdCount_o <= cmdCount_o + 32'd1;
        end
    end

endmodule

//--- test/tbClockGen.sv
`timescale 1ns/10ps

module tbClockGen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #5 clk_o = ~clk_o;      // 10 ns period
    end

endmodule

//--- verilog/mpuController.sv
`timescale 1ns/10ps

module mpuController (
    input  logic               clk,
    input  logic               rst,
    input  logic               en_i,
    output logic               busy_o,
    output logic               errorI2c_o,
    output mpuPkg::mpuWord_t   acX_o,
    output mpuPkg::mpuWord_t   acY_o,
    output mpuPkg::mpuWord_t   acZ_o,
    output mpuPkg::mpuWord_t   gyX_o,
    output mpuPkg::mpuWord_t   gyY_o,
    output mpuPkg::mpuWord_t   gyZ_o,
    output logic               sampleValid_o,
    // I2C byte engine
    output logic               enI2c_o,
    output logic               start_o,
    output logic               stop_o,
    output logic               ackNack_o,
    output logic               rw_o,
    output mpuPkg::mpuByte_t   outByte_o,
    input  logic               busy_i,
    input  logic               err_i,
    input  mpuPkg::mpuByte_t   inByte_i
);

    logic               reqValid;
    mpuPkg::cmdKind_t   reqKind;
    mpuPkg::mpuByte_t   reqReg;
    mpuPkg::mpuByte_t   reqData;
    logic               reqDone;
    logic               rxStrobe;
    mpuPkg::byteIdx_t   rxIdx;
    logic               burstEnd;

    mpuSessionCtrl uSession (
        .clk        (clk),
        .rst        (rst),
        .en_i       (en_i),
        .err_i      (err_i),
        .reqDone_i  (reqDone),
        .reqValid_o (reqValid),
        .reqKind_o  (reqKind),
        .reqReg_o   (reqReg),
        .reqData_o  (reqData),
        .busy_o     (busy_o),
        .errorI2c_o (errorI2c_o)
    );

    i2cCmdSequencer uSequencer (
        .clk        (clk),
        .rst        (rst),
        .reqValid_i (reqValid),
        .reqKind_i  (reqKind),
        .reqReg_i   (reqReg),
        .reqData_i  (reqData),
        .reqDone_o  (reqDone),
        .busy_i     (busy_i),
        .enI2c_o    (enI2c_o),
        .start_o    (start_o),
        .stop_o     (stop_o),
        .ackNack_o  (ackNack_o),
        .rw_o       (rw_o),
        .outByte_o  (outByte_o),
        .rxStrobe_o (rxStrobe),
        .rxIdx_o    (rxIdx),
        .burstEnd_o (burstEnd)
    );

    mpuSampleAssembler uAssembler (
        .clk           (clk),
        .rst           (rst),
        .rxStrobe_i    (rxStrobe),
        .rxIdx_i       (rxIdx),
        .inByte_i      (inByte_i),
        .burstEnd_i    (burstEnd),
        .acX_o         (acX_o),
        .acY_o         (acY_o),
        .acZ_o         (acZ_o),
        .gyX_o         (gyX_o),
        .gyY_o         (gyY_o),
        .gyZ_o         (gyZ_o),
        .sampleValid_o (sampleValid_o)
    );

endmodule

//--- verilog/mpuSampleAssembler.sv
`timescale 1ns/10ps
`include "mpu_config.svh"

module mpuSampleAssembler (
    input  logic               clk,
    input  logic               rst,
    input  logic               rxStrobe_i,
    input  mpuPkg::byteIdx_t   rxIdx_i,
    input  mpuPkg::mpuByte_t   inByte_i,
    input  logic               burstEnd_i,
    output mpuPkg::mpuWord_t   acX_o,
    output mpuPkg::mpuWord_t   acY_o,
    output mpuPkg::mpuWord_t   acZ_o,
    output mpuPkg::mpuWord_t   gyX_o,
    output mpuPkg::mpuWord_t   gyY_o,
    output mpuPkg::mpuWord_t   gyZ_o,
    output logic               sampleValid_o
);

    mpuPkg::mpuWord_t shadow [6];       // Acc X/Y/Z then gyro X/Y/Z
    mpuPkg::mpuWord_t merged [6];       // Shadows with the current byte placed
    logic             isTemp;
    logic [2:0]       wordSel;

    assign isTemp  = (rxIdx_i == mpuPkg::byteIdx_t'(`MPU_TEMP_FIRST)) ||
                     (rxIdx_i == mpuPkg::byteIdx_t'(`MPU_TEMP_FIRST + 1));
    // Gyro bytes come after the temperature pair
    assign wordSel = (rxIdx_i < mpuPkg::byteIdx_t'(`MPU_TEMP_FIRST)) ? rxIdx_i[3:1]
                                                                     : rxIdx_i[3:1] - 3'd1;

    always_comb begin
        merged = shadow;
        if (rxStrobe_i && !isTemp) begin
            if (rxIdx_i[0]) begin
                merged[wordSel][7:0]  = inByte_i;   // Odd index is low byte
            end else begin
                merged[wordSel][15:8] = inByte_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        shadow <= merged;
    end

    // Publish all six together so a set never mixes two bursts
    always_ff @(posedge clk) begin
        if (rst) begin
            acX_o         <= '0;
            acY_o         <= '0;
            acZ_o         <= '0;
            gyX_o         <= '0;
            gyY_o         <= '0;
            gyZ_o         <= '0;
            sampleValid_o <= 1'b0;
        end else begin
            sampleValid_o <= burstEnd_i;
            if (burstEnd_i) begin
                acX_o <= merged[0];
                acY_o <= merged[1];
                acZ_o <= merged[2];
                gyX_o <= merged[3];
                gyY_o <= merged[4];
                gyZ_o <= merged[5];     // Last byte arrives straight from the bus
            end
        end
    end

endmodule

//--- verilog/i2cCmdSequencer.sv
`timescale 1ns/10ps
`include "mpu_config.svh"

module i2cCmdSequencer (
    input  logic               clk,
    input  logic               rst,
    input  logic               reqValid_i,
    input  mpuPkg::cmdKind_t   reqKind_i,
    input  mpuPkg::mpuByte_t   reqReg_i,
    input  mpuPkg::mpuByte_t   reqData_i,
    output logic               reqDone_o,
    input  logic               busy_i,
    output logic               enI2c_o,
    output logic               start_o,
    output logic               stop_o,
    output logic               ackNack_o,
    output logic               rw_o,
    output mpuPkg::mpuByte_t   outByte_o,
    output logic               rxStrobe_o,
    output mpuPkg::byteIdx_t   rxIdx_o,
    output logic               burstEnd_o
);

    mpuPkg::cmdState_t step;
    logic              waitLow;     // Engine took the byte, wait for busy to drop
    mpuPkg::byteIdx_t  rxCnt;
    logic              lastRx;
    logic              byteDone;

    assign lastRx   = (rxCnt == mpuPkg::byteIdx_t'(`MPU_BURST_LEN - 1));
    assign byteDone = waitLow && !busy_i;

    ////////////////////////////////////////////////////////////////////////////
    // Byte steps
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            step    <= mpuPkg::CMD_IDLE;
            waitLow <= 1'b0;
            rxCnt   <= '0;
        end else if (!reqValid_i) begin
            step    <= mpuPkg::CMD_IDLE;    // Request abandoned
            waitLow <= 1'b0;
        end else if (step == mpuPkg::CMD_IDLE) begin
            step    <= mpuPkg::CMD_ADDR_W;
            waitLow <= 1'b0;
            rxCnt   <= '0;
        end else if (!waitLow) begin
            waitLow <= busy_i;
        end else if (!busy_i) begin
            waitLow <= 1'b0;
            case (step)
                mpuPkg::CMD_ADDR_W: step <= mpuPkg::CMD_REG;
                mpuPkg::CMD_REG: begin
                    step <= (reqKind_i == mpuPkg::KIND_READ) ? mpuPkg::CMD_ADDR_R
                                                             : mpuPkg::CMD_DATA;
                end
                mpuPkg::CMD_ADDR_R: step <= mpuPkg::CMD_RECV;
                mpuPkg::CMD_RECV: begin
                    if (lastRx) begin
                        step <= mpuPkg::CMD_IDLE;
                    end else begin
                        rxCnt <= rxCnt + 4'd1;
                    end
                end
                default: step <= mpuPkg::CMD_IDLE;     // Data byte ends a write
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Engine qualifiers, held for the whole byte
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        start_o   = 1'b0;
        stop_o    = 1'b0;
        ackNack_o = 1'b0;
        rw_o      = 1'b1;   // Transmit unless receiving
        outByte_o = 8'h00;
        case (step)
            mpuPkg::CMD_ADDR_W: begin
                start_o   = 1'b1;
                outByte_o = `MPU_ADDR_W;
            end
            mpuPkg::CMD_REG:  outByte_o = reqReg_i;
            mpuPkg::CMD_DATA: begin
                stop_o    = 1'b1;
                outByte_o = reqData_i;
            end
            mpuPkg::CMD_ADDR_R: begin
                start_o   = 1'b1;   // Repeated start
                outByte_o = `MPU_ADDR_R;
            end
            mpuPkg::CMD_RECV: begin
                rw_o      = 1'b0;
                ackNack_o = lastRx; // NACK closes the burst
                stop_o    = lastRx;
            end
            default: rw_o = 1'b0;
        endcase
    end

    assign enI2c_o    = reqValid_i && (step != mpuPkg::CMD_IDLE) && !waitLow;
    assign rxStrobe_o = byteDone && (step == mpuPkg::CMD_RECV);
    assign rxIdx_o    = rxCnt;
    assign burstEnd_o = rxStrobe_o && lastRx;
    assign reqDone_o  = byteDone && ((step == mpuPkg::CMD_DATA) || burstEnd_o);

    enDropsOnBusy: assert property (
        @(posedge clk) disable iff (rst)
        enI2c_o && busy_i |=> !enI2c_o
    );

    qualStableWhileBusy: assert property (
        @(posedge clk) disable iff (rst || !reqValid_i)
        busy_i && $past(busy_i) |-> $stable({start_o, stop_o, ackNack_o, rw_o, outByte_o})
    );

endmodule

//--- verilog/mpuSessionCtrl.sv
`timescale 1ns/10ps
`include "mpu_config.svh"

module mpuSessionCtrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               en_i,
    input  logic               err_i,
    input  logic               reqDone_i,
    output logic               reqValid_o,
    output mpuPkg::cmdKind_t   reqKind_o,
    output mpuPkg::mpuByte_t   reqReg_o,
    output mpuPkg::mpuByte_t   reqData_o,
    output logic               busy_o,
    output logic               errorI2c_o
);

    mpuPkg::sessState_t state;
    mpuPkg::sessState_t stateNext;

    ////////////////////////////////////////////////////////////////////////////
    // Session sequence
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        stateNext = state;
        case (state)
            mpuPkg::SESS_FSYNC: if (reqDone_i) stateNext = mpuPkg::SESS_LPF;
            mpuPkg::SESS_LPF:   if (reqDone_i) stateNext = mpuPkg::SESS_GYRO;
            mpuPkg::SESS_GYRO:  if (reqDone_i) stateNext = mpuPkg::SESS_ACC;
            mpuPkg::SESS_ACC:   if (reqDone_i) stateNext = mpuPkg::SESS_WAKE;
            mpuPkg::SESS_WAKE:  if (reqDone_i) stateNext = mpuPkg::SESS_IDLE;
            mpuPkg::SESS_IDLE:  if (en_i) stateNext = mpuPkg::SESS_READ;
            mpuPkg::SESS_READ:  if (reqDone_i) stateNext = mpuPkg::SESS_IDLE;
            mpuPkg::SESS_ERROR: stateNext = mpuPkg::SESS_ERROR;
            default:            stateNext = mpuPkg::SESS_ERROR;
        endcase
        if (err_i) begin
            stateNext = mpuPkg::SESS_ERROR;     // Any engine error is fatal
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mpuPkg::SESS_FSYNC;    // Init starts straight out of reset
        end else begin
            state <= stateNext;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request table
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        reqKind_o = mpuPkg::KIND_WRITE;
        reqReg_o  = 8'h00;
        reqData_o = 8'h00;
        case (state)
            mpuPkg::SESS_FSYNC: begin
                reqReg_o  = `MPU_REG_CONF;
                reqData_o = `MPU_VAL_FSYNC_OFF;
            end
            mpuPkg::SESS_LPF: begin
                reqReg_o  = `MPU_REG_CONF;     // Same register holds the DLPF field
                reqData_o = `MPU_VAL_LPF_184;
            end
            mpuPkg::SESS_GYRO: begin
                reqReg_o  = `MPU_REG_GYRO;
                reqData_o = `MPU_VAL_GYRO_250;
            end
            mpuPkg::SESS_ACC: begin
                reqReg_o  = `MPU_REG_ACC;
                reqData_o = `MPU_VAL_ACC_2G;
            end
            mpuPkg::SESS_WAKE: begin
                reqReg_o  = `MPU_REG_PWR;
                reqData_o = `MPU_VAL_WAKE;
            end
            mpuPkg::SESS_READ: begin
                reqKind_o = mpuPkg::KIND_READ;
                reqReg_o  = `MPU_REG_DATA;     // Burst from ACCEL_XOUT_H
            end
            default: begin
                reqKind_o = mpuPkg::KIND_WRITE;
            end
        endcase
    end

    assign reqValid_o = (state != mpuPkg::SESS_IDLE) && (state != mpuPkg::SESS_ERROR);
    assign busy_o     = (state != mpuPkg::SESS_IDLE) && (state != mpuPkg::SESS_ERROR);
    assign errorI2c_o = (state == mpuPkg::SESS_ERROR);

    // An engine error abandons the pending request on the next cycle
    errorDropsRequest: assert property (
        @(posedge clk) disable iff (rst)
        err_i |=> errorI2c_o && !reqValid_o
    );

endmodule

//--- verilog/mpuPkg.sv
package mpuPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [7:0]  mpuByte_t;     // One byte on the bus
    typedef logic [15:0] mpuWord_t;     // One sensor reading
    typedef logic [3:0]  byteIdx_t;     // Position inside a 14 byte burst

    ////////////////////////////////////////////////////////////////////////////
    // State machines
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        SESS_FSYNC,     // Init write 1
        SESS_LPF,
        SESS_GYRO,
        SESS_ACC,
        SESS_WAKE,      // Init write 5
        SESS_IDLE,
        SESS_READ,      // Sample burst in flight
        SESS_ERROR      // Sticky until reset
    } sessState_t;

    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_ADDR_W,     // Start + write address
        CMD_REG,        // Register pointer
        CMD_DATA,       // Write data + stop
        CMD_ADDR_R,     // Repeated start + read address
        CMD_RECV        // Burst receive bytes
    } cmdState_t;

    typedef enum logic {
        KIND_WRITE,
        KIND_READ
    } cmdKind_t;

endpackage

//--- verilog/mpu_config.svh
`ifndef MPU_CONFIG_SVH
`define MPU_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Slave addresses, 7-bit 0x68 with the R/W bit appended
////////////////////////////////////////////////////////////////////////////
`define MPU_ADDR_W          8'hD0   // Write transfer
`define MPU_ADDR_R          8'hD1   // Read transfer

////////////////////////////////////////////////////////////////////////////
// Register map, only the entries this controller touches
////////////////////////////////////////////////////////////////////////////
`define MPU_REG_CONF        8'h1A   // FSYNC and DLPF
`define MPU_REG_GYRO        8'h1B   // Gyro full scale
`define MPU_REG_ACC         8'h1C   // Accel full scale
`define MPU_REG_PWR         8'h6B   // PWR_MGMT_1
`define MPU_REG_DATA        8'h3B   // ACCEL_XOUT_H, start of burst

////////////////////////////////////////////////////////////////////////////
// Configuration values written at power-up
////////////////////////////////////////////////////////////////////////////
`define MPU_VAL_FSYNC_OFF   8'h00   // No frame sync input
`define MPU_VAL_LPF_184     8'h01   // 184 Hz, 1 kHz gyro rate
`define MPU_VAL_GYRO_250    8'h00   // +-250 deg/s
`define MPU_VAL_ACC_2G      8'h00   // +-2 g
`define MPU_VAL_WAKE        8'h00   // Clear sleep bit

////////////////////////////////////////////////////////////////////////////
// Sample burst layout
////////////////////////////////////////////////////////////////////////////
// Accel X/Y/Z, temperature, gyro X/Y/Z, all big-endian pairs
`define MPU_BURST_LEN       14
`define MPU_TEMP_FIRST      6       // Temperature bytes sit at 6 and 7

`endif
